//--- filelist.f
+incdir+common
common/io_pad_pkg.sv
src/blink_counter.sv
src/gpio_regs.sv
io_mux/io_multiplexer.sv
src/user_io_top.sv
verif/tb_user_io.sv

//--- verif/tb_user_io.sv
`timescale 1ns/1ps
`include "io_pad_consts.svh"

module tb_user_io
	import io_pad_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 4000;
	localparam int HI_BITS = `MPRJ_IO_PADS - `GPIO_LO_BITS;

	logic                     clk;
	logic                     rst;
	logic                     reg_wr;
	logic                     reg_rd;
	gpio_reg_e                reg_sel;
	logic [`GPIO_LO_BITS-1:0] reg_wdata;
	logic [`GPIO_LO_BITS-1:0] reg_rdata;
	logic                     reg_rvalid;
	logic [`MPRJ_IO_PADS-1:0] io_in;
	logic [`MPRJ_IO_PADS-1:0] io_out;
	logic [`MPRJ_IO_PADS-1:0] io_oeb;
	logic [3:1]               uart_en;
	logic [3:1]               uart_rx;
	logic [3:1]               uart_tx;
	logic [0:0]               spi_en;
	logic [0:0]               spi_clk;
	logic [0:0]               spi_mosi;
	logic [0:0]               spi_miso;
	logic [0:0]               spi_cs;
	logic [7:0]               pwm_en;
	logic [7:0]               pwm_out;
	logic                     jtag_tck;
	logic                     jtag_tms;
	logic                     jtag_tdi;
	logic                     jtag_tdo;
	logic                     flash_csb;
	logic                     flash_sck;
	logic                     flash_io0_we;
	logic                     flash_io0_write;
	logic                     flash_io0_read;
	logic                     flash_io1_we;
	logic                     flash_io1_write;
	logic                     flash_io1_read;
	logic                     irq_en;
	logic                     irq_in;
	logic [1:0]               vga_r;
	logic [1:0]               vga_g;
	logic [1:0]               vga_b;
	logic                     vga_vsync;
	logic                     vga_hsync;
	logic [1:0]               probe_blink;

	// Reference state of the GPIO registers, blink ownership and blink count
	logic [`MPRJ_IO_PADS-1:0] model_out;
	logic [`MPRJ_IO_PADS-1:0] model_oeb;
	logic                     blink_on;
	int                       active_cycles;
	logic [1:0]               blink_model;

	string test_name;
	int    test_errors;
	int    passed;
	int    failed;
	int    cycle_count;

	user_io_top #(
		.BLINK_DIV(3)
	) uut (.*);

	initial begin
		clk = 1'b0;
	end

	always #50 clk = ~clk;

	// Probe steps once every 8 clocks out of reset
	always @(posedge clk) begin
		if (rst) begin
			active_cycles <= 0;
		end else if (blink_on) begin
			active_cycles <= active_cycles + 1;
		end
	end

	assign blink_model = active_cycles[4:3];

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic wait_cycle();
		@(posedge clk);
		#5;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		if (test_errors == 0) begin
			passed++;
			$display("[PASS] %s", test_name);
		end else begin
			failed++;
			$display("[FAIL] %s: %0d errors", test_name, test_errors);
		end
	endtask

	task automatic check_equal(
		input string       what,
		input logic [63:0] expected,
		input logic [63:0] actual
	);
		assert (actual === expected) else begin
			$display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h",
				test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	function automatic logic [`MPRJ_IO_PADS-1:0] random_pads();
		logic [63:0] r;
		r = {$urandom, $urandom};
		return r[`MPRJ_IO_PADS-1:0];
	endfunction

	// Who holds each pad given the enables and the blink state
	function automatic pad_owner_e pad_owner(input int pad);
		if (pad == `PIN_BLINK0 || pad == `PIN_BLINK1) begin
			return blink_on ? OWN_BLINK : OWN_GPIO;
		end
		if (pad == `PIN_IRQ) begin
			return irq_en ? OWN_PERIPH : OWN_GPIO;
		end
		if (pad >= `PIN_PWM0 && pad <= `PIN_PWM6) begin
			return pwm_en[pad - `PIN_PWM0] ? OWN_PERIPH : OWN_GPIO;
		end
		if (pad == `PIN_PWM7) begin
			return pwm_en[7] ? OWN_PERIPH : OWN_GPIO;
		end
		if (pad == `PIN_UART2_RX || pad == `PIN_UART2_TX) begin
			return uart_en[2] ? OWN_PERIPH : OWN_GPIO;
		end
		if (pad == `PIN_UART3_RX || pad == `PIN_UART3_TX) begin
			return uart_en[3] ? OWN_PERIPH : OWN_GPIO;
		end
		if (pad >= `PIN_SPI0_CLK && pad <= `PIN_SPI0_CS) begin
			return spi_en[0] ? OWN_PERIPH : OWN_GPIO;
		end
		return OWN_PERIPH;
	endfunction

	// Function drive of a pad as {out, oeb}
	function automatic logic [1:0] periph_drive(input int pad);
		logic [7:0] vga;
		vga = {vga_hsync, vga_vsync, vga_b, vga_g, vga_r};
		if (pad >= `PIN_VGA_R0) begin
			return {vga[pad - `PIN_VGA_R0], 1'b0};
		end
		if (pad >= `PIN_PWM0 && pad <= `PIN_PWM6) begin
			return {pwm_out[pad - `PIN_PWM0], 1'b0};
		end
		case (pad)
			`PIN_SDO: return {jtag_tdo, 1'b0};
			`PIN_UART1_TX: return {uart_tx[1], 1'b0};
			`PIN_FLASH_CSB: return {flash_csb, 1'b0};
			`PIN_FLASH_SCK: return {flash_sck, 1'b0};
			`PIN_FLASH_IO0: return {flash_io0_write, !flash_io0_we};
			`PIN_FLASH_IO1: return {flash_io1_write, !flash_io1_we};
			`PIN_PWM7: return {pwm_out[7], 1'b0};
			`PIN_UART2_TX: return {uart_tx[2], 1'b0};
			`PIN_UART3_TX: return {uart_tx[3], 1'b0};
			`PIN_SPI0_CLK: return {spi_clk[0], 1'b0};
			`PIN_SPI0_MOSI: return {spi_mosi[0], 1'b0};
			`PIN_SPI0_CS: return {spi_cs[0], 1'b0};
			// JTAG, SDI, CSB, SCK, rx lines, IRQ and MISO
			default: return 2'b01;
		endcase
	endfunction

	function automatic logic [1:0] pad_expected(input int pad);
		case (pad_owner(pad))
			OWN_GPIO: return {model_out[pad], model_oeb[pad]};
			OWN_BLINK: return {blink_model[pad - `PIN_BLINK0], 1'b0};
			default: return periph_drive(pad);
		endcase
	endfunction

	function automatic logic [`MPRJ_IO_PADS-1:0] gpio_input_expected();
		logic [`MPRJ_IO_PADS-1:0] bits;
		for (int i = 0; i < `MPRJ_IO_PADS; i++) begin
			bits[i] = (pad_owner(i) == OWN_GPIO) && model_oeb[i] && io_in[i];
		end
		return bits;
	endfunction

	task automatic compare_pads(input string what);
		logic [`MPRJ_IO_PADS-1:0] exp_out;
		logic [`MPRJ_IO_PADS-1:0] exp_oeb;
		logic [1:0]               drive;
		for (int i = 0; i < `MPRJ_IO_PADS; i++) begin
			drive = pad_expected(i);
			exp_out[i] = drive[1];
			exp_oeb[i] = drive[0];
		end
		check_equal({what, " io_oeb"}, exp_oeb, io_oeb);
		check_equal({what, " io_out"}, exp_out, io_out);
	endtask

	task automatic apply_reset();
		wait_cycle();
		rst = 1'b1;
		blink_on = 1'b1;
		model_out = '0;
		model_oeb = '1;
		repeat (16) wait_cycle();
		rst = 1'b0;
	endtask

	task automatic reg_write(input gpio_reg_e sel, input logic [31:0] data);
		wait_cycle();
		reg_wr = 1'b1;
		reg_sel = sel;
		reg_wdata = data;
		wait_cycle();
		reg_wr = 1'b0;
		case (sel)
			REG_OUT_LO: model_out[`GPIO_LO_BITS-1:0] = data;
			REG_OUT_HI: model_out[`MPRJ_IO_PADS-1:`GPIO_LO_BITS] = data[HI_BITS-1:0];
			REG_OEB_LO: model_oeb[`GPIO_LO_BITS-1:0] = data;
			REG_OEB_HI: model_oeb[`MPRJ_IO_PADS-1:`GPIO_LO_BITS] = data[HI_BITS-1:0];
			default: ;
		endcase
	endtask

	// Valid must be low on the strobe cycle, high one cycle later, then low
	task automatic reg_read(input gpio_reg_e sel, output logic [31:0] data);
		wait_cycle();
		reg_rd = 1'b1;
		reg_sel = sel;
		#10;
		check_equal("reg_rvalid on strobe", 1'b0, reg_rvalid);
		wait_cycle();
		reg_rd = 1'b0;
		#10;
		check_equal("reg_rvalid after strobe", 1'b1, reg_rvalid);
		data = reg_rdata;
		wait_cycle();
		#10;
		check_equal("reg_rvalid pulse end", 1'b0, reg_rvalid);
	endtask

	task automatic reset_state();
		start_test("reset_state");
		#10;
		check_equal("reg_rvalid", 1'b0, reg_rvalid);
		compare_pads("after reset");
		repeat (40) begin
			wait_cycle();
			#10;
			check_equal("probe_blink", blink_model, probe_blink);
			compare_pads("blink pads");
		end
		finish_test();
	endtask

	task automatic fixed_routes();
		logic [31:0] r;
		start_test("fixed_routes");
		repeat (24) begin
			wait_cycle();
			r = $urandom;
			uart_en[1] = 1'b1;
			{jtag_tdo, uart_tx[1], flash_csb, flash_sck} = r[3:0];
			{flash_io0_we, flash_io0_write, flash_io1_we, flash_io1_write} = r[7:4];
			{vga_hsync, vga_vsync, vga_b, vga_g, vga_r} = r[15:8];
			io_in = random_pads();
			#10;
			compare_pads("fixed pads");
			check_equal("jtag_tck", io_in[`PIN_SCK], jtag_tck);
			check_equal("jtag_tms", io_in[`PIN_CSB], jtag_tms);
			check_equal("jtag_tdi", io_in[`PIN_SDI], jtag_tdi);
			check_equal("uart1 rx", io_in[`PIN_UART1_RX], uart_rx[1]);
			check_equal("flash io0 read",
				flash_io0_we ? 1'b0 : io_in[`PIN_FLASH_IO0], flash_io0_read);
			check_equal("flash io1 read",
				flash_io1_we ? 1'b0 : io_in[`PIN_FLASH_IO1], flash_io1_read);
		end
		finish_test();
	endtask

	task automatic shared_peripherals();
		logic [31:0] r;
		start_test("shared_peripherals");
		// Distinct GPIO drive so stray ownership shows up
		reg_write(REG_OUT_LO, $urandom);
		reg_write(REG_OUT_HI, $urandom);
		reg_write(REG_OEB_LO, $urandom | (32'd1 << `PIN_BLINK0));
		reg_write(REG_OEB_HI, $urandom);
		for (int k = 0; k < 12; k++) begin
			wait_cycle();
			r = $urandom;
			irq_en = 1'b0;
			pwm_en = '0;
			uart_en = '0;
			spi_en = '0;
			pwm_out = r[7:0];
			uart_tx = r[10:8];
			{spi_clk, spi_mosi, spi_cs} = r[13:11];
			io_in = random_pads();
			if (k == 0) begin
				irq_en = 1'b1;
			end else if (k <= 8) begin
				pwm_en[k-1] = 1'b1;
			end else if (k == 9) begin
				uart_en[2] = 1'b1;
			end else if (k == 10) begin
				uart_en[3] = 1'b1;
			end else begin
				spi_en = 1'b1;
			end
			#10;
			compare_pads("shared pads");
			check_equal("irq_in", irq_en ? io_in[`PIN_IRQ] : 1'b0, irq_in);
			check_equal("spi_miso", spi_en[0] ? io_in[`PIN_SPI0_MISO] : 1'b0, spi_miso);
			check_equal("uart1 rx idle", 1'b1, uart_rx[1]);
			check_equal("uart2 rx", uart_en[2] ? io_in[`PIN_UART2_RX] : 1'b1, uart_rx[2]);
			check_equal("uart3 rx", uart_en[3] ? io_in[`PIN_UART3_RX] : 1'b1, uart_rx[3]);
		end
		finish_test();
	endtask

	task automatic gpio_registers();
		logic [31:0]              data;
		logic [`MPRJ_IO_PADS-1:0] expected_in;
		start_test("gpio_registers");
		wait_cycle();
		irq_en = 1'b0;
		pwm_en = '0;
		uart_en = '0;
		spi_en = '0;
		repeat (12) begin
			reg_write(REG_OUT_LO, $urandom);
			#10;
			compare_pads("OUT_LO write");
			reg_write(REG_OUT_HI, $urandom);
			#10;
			compare_pads("OUT_HI write");
			// Bit 28 stays set so the blink probe keeps its pads
			reg_write(REG_OEB_LO, $urandom | (32'd1 << `PIN_BLINK0));
			#10;
			compare_pads("OEB_LO write");
			reg_write(REG_OEB_HI, $urandom);
			#10;
			compare_pads("OEB_HI write");
			wait_cycle();
			io_in = random_pads();
			expected_in = gpio_input_expected();
			wait_cycle();
			reg_read(REG_IN_LO, data);
			check_equal("REG_IN_LO", expected_in[`GPIO_LO_BITS-1:0], data);
			reg_read(REG_IN_HI, data);
			check_equal("REG_IN_HI", {26'd0, expected_in[`MPRJ_IO_PADS-1:`GPIO_LO_BITS]}, data);
			reg_read(REG_OEB_HI, data);
			check_equal("REG_OEB_HI", {26'd0, model_oeb[`MPRJ_IO_PADS-1:`GPIO_LO_BITS]}, data);
			// Pads 32 and up are VGA, so the HI output word only shows on readback
			reg_read(REG_OUT_HI, data);
			check_equal("REG_OUT_HI", {26'd0, model_out[`MPRJ_IO_PADS-1:`GPIO_LO_BITS]}, data);
		end
		finish_test();
	endtask

	task automatic blink_handover();
		start_test("blink_handover");
		wait_cycle();
		#10;
		compare_pads("before handover");
		reg_write(REG_OUT_LO, $urandom);
		reg_write(REG_OEB_LO, $urandom & ~(32'd1 << `PIN_BLINK0));
		// Ownership moves one cycle after the OEB write lands
		wait_cycle();
		blink_on = 1'b0;
		#10;
		compare_pads("after handover");
		repeat (20) wait_cycle();
		#10;
		check_equal("frozen probe_blink", blink_model, probe_blink);
		compare_pads("GPIO on blink pads");
		apply_reset();
		repeat (24) begin
			wait_cycle();
			#10;
			check_equal("restored probe_blink", blink_model, probe_blink);
			compare_pads("blink restored");
		end
		finish_test();
	endtask

	initial begin
		void'($urandom(32'hc12db2a5));
		rst = 1'b1;
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		reg_sel = REG_OUT_LO;
		reg_wdata = '0;
		io_in = '0;
		uart_en = '0;
		uart_tx = '0;
		spi_en = '0;
		spi_clk = '0;
		spi_mosi = '0;
		spi_cs = '0;
		pwm_en = '0;
		pwm_out = '0;
		jtag_tdo = 1'b0;
		flash_csb = 1'b0;
		flash_sck = 1'b0;
		flash_io0_we = 1'b0;
		flash_io0_write = 1'b0;
		flash_io1_we = 1'b0;
		flash_io1_write = 1'b0;
		irq_en = 1'b0;
		vga_r = '0;
		vga_g = '0;
		vga_b = '0;
		vga_vsync = 1'b0;
		vga_hsync = 1'b0;
		blink_on = 1'b1;
		model_out = '0;
		model_oeb = '1;
		passed = 0;
		failed = 0;
		cycle_count = 0;

		apply_reset();
		reset_state();
		fixed_routes();
		shared_peripherals();
		gpio_registers();
		blink_handover();

		$display("Tests passed: %0d, failed: %0d", passed, failed);
		if (failed == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- src/user_io_top.sv
`timescale 1ns/1ps
`include "io_pad_consts.svh"

module user_io_top
	import io_pad_pkg::*;
#(
	parameter int BLINK_DIV = `BLINK_CLOCK_DIV
) (
	input  logic                     clk,
	input  logic                     rst,

	input  logic                     reg_wr,
	input  logic                     reg_rd,
	input  gpio_reg_e                reg_sel,
	input  logic [`GPIO_LO_BITS-1:0] reg_wdata,
	output logic [`GPIO_LO_BITS-1:0] reg_rdata,
	output logic                     reg_rvalid,

	input  logic [`MPRJ_IO_PADS-1:0] io_in,
	output logic [`MPRJ_IO_PADS-1:0] io_out,
	output logic [`MPRJ_IO_PADS-1:0] io_oeb,

	input  logic [3:1]               uart_en,
	output logic [3:1]               uart_rx,
	input  logic [3:1]               uart_tx,
	input  logic [0:0]               spi_en,
	input  logic [0:0]               spi_clk,
	input  logic [0:0]               spi_mosi,
	output logic [0:0]               spi_miso,
	input  logic [0:0]               spi_cs,
	input  logic [7:0]               pwm_en,
	input  logic [7:0]               pwm_out,
	output logic                     jtag_tck,
	output logic                     jtag_tms,
	output logic                     jtag_tdi,
	input  logic                     jtag_tdo,
	input  logic                     flash_csb,
	input  logic                     flash_sck,
	input  logic                     flash_io0_we,
	input  logic                     flash_io0_write,
	output logic                     flash_io0_read,
	input  logic                     flash_io1_we,
	input  logic                     flash_io1_write,
	output logic                     flash_io1_read,
	input  logic                     irq_en,
	output logic                     irq_in,
	input  logic [1:0]               vga_r,
	input  logic [1:0]               vga_g,
	input  logic [1:0]               vga_b,
	input  logic                     vga_vsync,
	input  logic                     vga_hsync,

	output logic [1:0]               probe_blink
);

	logic [`MPRJ_IO_PADS-1:0] gpio_input;
	logic [`MPRJ_IO_PADS-1:0] gpio_output;
	logic [`MPRJ_IO_PADS-1:0] gpio_oeb;
	logic [1:0]               blink;
	logic                     blink_active;

	gpio_regs u_gpio_regs (
		.clk        (clk),
		.rst        (rst),
		.reg_wr     (reg_wr),
		.reg_rd     (reg_rd),
		.reg_sel    (reg_sel),
		.reg_wdata  (reg_wdata),
		.reg_rdata  (reg_rdata),
		.reg_rvalid (reg_rvalid),
		.gpio_input (gpio_input),
		.gpio_output(gpio_output),
		.gpio_oeb   (gpio_oeb)
	);

	io_multiplexer u_io_mux (
		.clk            (clk),
		.rst            (rst),
		.uart_en        (uart_en),
		.uart_rx        (uart_rx),
		.uart_tx        (uart_tx),
		.spi_en         (spi_en),
		.spi_clk        (spi_clk),
		.spi_mosi       (spi_mosi),
		.spi_miso       (spi_miso),
		.spi_cs         (spi_cs),
		.pwm_en         (pwm_en),
		.pwm_out        (pwm_out),
		.gpio_input     (gpio_input),
		.gpio_output    (gpio_output),
		.gpio_oeb       (gpio_oeb),
		.io_in          (io_in),
		.io_out         (io_out),
		.io_oeb         (io_oeb),
		.jtag_tck       (jtag_tck),
		.jtag_tms       (jtag_tms),
		.jtag_tdi       (jtag_tdi),
		.jtag_tdo       (jtag_tdo),
		.flash_csb      (flash_csb),
		.flash_sck      (flash_sck),
		.flash_io0_we   (flash_io0_we),
		.flash_io0_write(flash_io0_write),
		.flash_io0_read (flash_io0_read),
		.flash_io1_we   (flash_io1_we),
		.flash_io1_write(flash_io1_write),
		.flash_io1_read (flash_io1_read),
		.irq_en         (irq_en),
		.irq_in         (irq_in),
		.vga_r          (vga_r),
		.vga_g          (vga_g),
		.vga_b          (vga_b),
		.vga_vsync      (vga_vsync),
		.vga_hsync      (vga_hsync),
		.blink          (blink),
		.blink_active   (blink_active)
	);

	// Counter freezes once the probe is handed to GPIO
	blink_counter #(
		.WIDTH(2),
		.DIV  (BLINK_DIV)
	) u_blink (
		.clk  (clk),
		.rst  (rst),
		.halt (!blink_active),
		.value(blink)
	);

	assign probe_blink = blink;

endmodule

//--- io_mux/io_multiplexer.sv
`timescale 1ns/1ps
`include "io_pad_consts.svh"

module io_multiplexer
	import io_pad_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,

	input  logic [3:1]               uart_en,
	output logic [3:1]               uart_rx,
	input  logic [3:1]               uart_tx,

	input  logic [0:0]               spi_en,
	input  logic [0:0]               spi_clk,
	input  logic [0:0]               spi_mosi,
	output logic [0:0]               spi_miso,
	input  logic [0:0]               spi_cs,

	input  logic [7:0]               pwm_en,
	input  logic [7:0]               pwm_out,

	output logic [`MPRJ_IO_PADS-1:0] gpio_input,
	input  logic [`MPRJ_IO_PADS-1:0] gpio_output,
	input  logic [`MPRJ_IO_PADS-1:0] gpio_oeb,

	input  logic [`MPRJ_IO_PADS-1:0] io_in,
	output logic [`MPRJ_IO_PADS-1:0] io_out,
	output logic [`MPRJ_IO_PADS-1:0] io_oeb,

	output logic                     jtag_tck,
	output logic                     jtag_tms,
	output logic                     jtag_tdi,
	input  logic                     jtag_tdo,

	input  logic                     flash_csb,
	input  logic                     flash_sck,
	input  logic                     flash_io0_we,
	input  logic                     flash_io0_write,
	output logic                     flash_io0_read,
	input  logic                     flash_io1_we,
	input  logic                     flash_io1_write,
	output logic                     flash_io1_read,

	input  logic                     irq_en,
	output logic                     irq_in,

	input  logic [1:0]               vga_r,
	input  logic [1:0]               vga_g,
	input  logic [1:0]               vga_b,
	input  logic                     vga_vsync,
	input  logic                     vga_hsync,

	input  logic [1:0]               blink,
	output logic                     blink_active
);

	logic [`MPRJ_IO_PADS-1:0] periph_en;
	logic [`MPRJ_IO_PADS-1:0] periph_out;
	logic [`MPRJ_IO_PADS-1:0] periph_oeb;
	pad_owner_e owner [`MPRJ_IO_PADS];

	// Blink probe keeps pads 28/29 until GPIO drives pad 28
	always_ff @(posedge clk) begin
		if (rst) begin
			blink_active <= 1'b1;
		end else if (!gpio_oeb[`PIN_BLINK0]) begin
			blink_active <= 1'b0;
		end
	end

	// Fixed pads keep periph_en high
	always_comb begin
		periph_en = '1;
		periph_out = '0;
		periph_oeb = '1;

		// Pad 0 of the management link has no user-side consumer
		periph_out[`PIN_SDO] = jtag_tdo;
		periph_oeb[`PIN_SDO] = 1'b0;
		periph_out[`PIN_UART1_TX] = uart_tx[1];
		periph_oeb[`PIN_UART1_TX] = 1'b0;

		periph_en[`PIN_IRQ] = irq_en;

		periph_out[`PIN_FLASH_CSB] = flash_csb;
		periph_oeb[`PIN_FLASH_CSB] = 1'b0;
		periph_out[`PIN_FLASH_SCK] = flash_sck;
		periph_oeb[`PIN_FLASH_SCK] = 1'b0;
		periph_out[`PIN_FLASH_IO0] = flash_io0_write;
		periph_oeb[`PIN_FLASH_IO0] = !flash_io0_we;
		periph_out[`PIN_FLASH_IO1] = flash_io1_write;
		periph_oeb[`PIN_FLASH_IO1] = !flash_io1_we;

		// PWM0-6 sit on consecutive pads
		periph_en[`PIN_PWM6:`PIN_PWM0] = pwm_en[6:0];
		periph_out[`PIN_PWM6:`PIN_PWM0] = pwm_out[6:0];
		periph_oeb[`PIN_PWM6:`PIN_PWM0] = '0;
		periph_en[`PIN_PWM7] = pwm_en[7];
		periph_out[`PIN_PWM7] = pwm_out[7];
		periph_oeb[`PIN_PWM7] = 1'b0;

		periph_en[`PIN_UART2_RX] = uart_en[2];
		periph_en[`PIN_UART2_TX] = uart_en[2];
		periph_out[`PIN_UART2_TX] = uart_tx[2];
		periph_oeb[`PIN_UART2_TX] = 1'b0;
		periph_en[`PIN_UART3_RX] = uart_en[3];
		periph_en[`PIN_UART3_TX] = uart_en[3];
		periph_out[`PIN_UART3_TX] = uart_tx[3];
		periph_oeb[`PIN_UART3_TX] = 1'b0;

		periph_en[`PIN_SPI0_CS:`PIN_SPI0_CLK] = {4{spi_en[0]}};
		periph_out[`PIN_SPI0_CLK] = spi_clk[0];
		periph_oeb[`PIN_SPI0_CLK] = 1'b0;
		periph_out[`PIN_SPI0_MOSI] = spi_mosi[0];
		periph_oeb[`PIN_SPI0_MOSI] = 1'b0;
		periph_out[`PIN_SPI0_CS] = spi_cs[0];
		periph_oeb[`PIN_SPI0_CS] = 1'b0;

		// Blink pads belong to blink or GPIO and never to a peripheral
		periph_en[`PIN_BLINK1:`PIN_BLINK0] = 2'b00;
		periph_out[`PIN_BLINK1:`PIN_BLINK0] = blink;

		periph_out[`PIN_VGA_HSYNC:`PIN_VGA_R0] = {vga_hsync, vga_vsync, vga_b, vga_g, vga_r};
		periph_oeb[`PIN_VGA_HSYNC:`PIN_VGA_R0] = '0;
	end

	always_comb begin
		for (int i = 0; i < `MPRJ_IO_PADS; i++) begin
			owner[i] = periph_en[i] ? OWN_PERIPH : OWN_GPIO;
		end
		if (blink_active) begin
			owner[`PIN_BLINK0] = OWN_BLINK;
			owner[`PIN_BLINK1] = OWN_BLINK;
		end
	end

	// GPIO only sees the input pads it owns
	always_comb begin
		for (int i = 0; i < `MPRJ_IO_PADS; i++) begin
			case (owner[i])
				OWN_PERIPH: begin
					io_out[i] = periph_out[i];
					io_oeb[i] = periph_oeb[i];
					gpio_input[i] = 1'b0;
				end
				OWN_BLINK: begin
					io_out[i] = periph_out[i];
					io_oeb[i] = 1'b0;
					gpio_input[i] = 1'b0;
				end
				default: begin
					io_out[i] = gpio_output[i];
					io_oeb[i] = gpio_oeb[i];
					gpio_input[i] = gpio_oeb[i] & io_in[i];
				end
			endcase
		end
	end

	// UART rx idles high while its UART is off
	assign jtag_tck = io_in[`PIN_SCK];
	assign jtag_tms = io_in[`PIN_CSB];
	assign jtag_tdi = io_in[`PIN_SDI];
	assign uart_rx[1] = uart_en[1] ? io_in[`PIN_UART1_RX] : 1'b1;
	assign uart_rx[2] = uart_en[2] ? io_in[`PIN_UART2_RX] : 1'b1;
	assign uart_rx[3] = uart_en[3] ? io_in[`PIN_UART3_RX] : 1'b1;
	assign irq_in = irq_en ? io_in[`PIN_IRQ] : 1'b0;
	assign spi_miso[0] = spi_en[0] ? io_in[`PIN_SPI0_MISO] : 1'b0;
	assign flash_io0_read = !flash_io0_we ? io_in[`PIN_FLASH_IO0] : 1'b0;
	assign flash_io1_read = !flash_io1_we ? io_in[`PIN_FLASH_IO1] : 1'b0;

endmodule

//--- src/gpio_regs.sv
`timescale 1ns/1ps
`include "io_pad_consts.svh"

module gpio_regs
	import io_pad_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     reg_wr,
	input  logic                     reg_rd,
	input  gpio_reg_e                reg_sel,
	input  logic [`GPIO_LO_BITS-1:0] reg_wdata,
	output logic [`GPIO_LO_BITS-1:0] reg_rdata,
	output logic                     reg_rvalid,
	input  logic [`MPRJ_IO_PADS-1:0] gpio_input,
	output logic [`MPRJ_IO_PADS-1:0] gpio_output,
	output logic [`MPRJ_IO_PADS-1:0] gpio_oeb
);

	// Pads 32 and up live in the HI words
	localparam int HI_BITS = `MPRJ_IO_PADS - `GPIO_LO_BITS;
	localparam int HI_PAD = `GPIO_LO_BITS - HI_BITS;

	logic [`MPRJ_IO_PADS-1:0] in_meta;
	logic [`MPRJ_IO_PADS-1:0] in_sync;
	logic [`GPIO_LO_BITS-1:0] rd_word;

	// All pads come out of reset as inputs
	always_ff @(posedge clk) begin
		if (rst) begin
			gpio_output <= '0;
			gpio_oeb <= '1;
		end else if (reg_wr) begin
			case (reg_sel)
				REG_OUT_LO: gpio_output[`GPIO_LO_BITS-1:0] <= reg_wdata;
				REG_OUT_HI: begin
					gpio_output[`MPRJ_IO_PADS-1:`GPIO_LO_BITS] <= reg_wdata[HI_BITS-1:0];
				end
				REG_OEB_LO: gpio_oeb[`GPIO_LO_BITS-1:0] <= reg_wdata;
				REG_OEB_HI: begin
					gpio_oeb[`MPRJ_IO_PADS-1:`GPIO_LO_BITS] <= reg_wdata[HI_BITS-1:0];
				end
				// Input words are read-only
				default: ;
			endcase
		end
	end

	// Two-flop synchronizer on the pad inputs
	always_ff @(posedge clk) begin
		in_meta <= gpio_input;
		in_sync <= in_meta;
	end

	// Word picked by the select
	always_comb begin
		case (reg_sel)
			REG_OUT_LO: rd_word = gpio_output[`GPIO_LO_BITS-1:0];
			REG_OUT_HI: begin
				rd_word = {{HI_PAD{1'b0}}, gpio_output[`MPRJ_IO_PADS-1:`GPIO_LO_BITS]};
			end
			REG_OEB_LO: rd_word = gpio_oeb[`GPIO_LO_BITS-1:0];
			REG_OEB_HI: begin
				rd_word = {{HI_PAD{1'b0}}, gpio_oeb[`MPRJ_IO_PADS-1:`GPIO_LO_BITS]};
			end
			REG_IN_LO: rd_word = in_sync[`GPIO_LO_BITS-1:0];
			REG_IN_HI: begin
				rd_word = {{HI_PAD{1'b0}}, in_sync[`MPRJ_IO_PADS-1:`GPIO_LO_BITS]};
			end
			default: rd_word = '0;
		endcase
	end

	// Read data lands one cycle after the strobe together with the valid pulse
	always_ff @(posedge clk) begin
		if (reg_rd) begin
			reg_rdata <= rd_word;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			reg_rvalid <= 1'b0;
		end else begin
			reg_rvalid <= reg_rd;
		end
	end

endmodule

//--- src/blink_counter.sv
`timescale 1ns/1ps
`include "io_pad_consts.svh"

module blink_counter #(
	parameter int WIDTH = 2,
	parameter int DIV = `BLINK_CLOCK_DIV
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             halt,
	output logic [WIDTH-1:0] value
);

	// Value steps once per full wrap of the free-running prescaler
	logic [DIV-1:0] prescale;

	always_ff @(posedge clk) begin
		if (rst) begin
			prescale <= '0;
			value <= '0;
		end else if (!halt) begin
			prescale <= prescale + 1'b1;
			if (&prescale) begin
				value <= value + 1'b1;
			end
		end
	end

endmodule

//--- common/io_pad_pkg.sv
package io_pad_pkg;

	// Register word select for the GPIO block
	typedef enum logic [2:0] {
		REG_OUT_LO = 3'd0,
		REG_OUT_HI = 3'd1,
		REG_OEB_LO = 3'd2,
		REG_OEB_HI = 3'd3,
		REG_IN_LO  = 3'd4,
		REG_IN_HI  = 3'd5
	} gpio_reg_e;

	// Current holder of a pad
	typedef enum logic [1:0] {
		OWN_GPIO   = 2'd0,
		OWN_PERIPH = 2'd1,
		OWN_BLINK  = 2'd2
	} pad_owner_e;

endpackage

//--- common/io_pad_consts.svh
`ifndef IO_PAD_CONSTS_SVH
`define IO_PAD_CONSTS_SVH

`define MPRJ_IO_PADS 38
`define GPIO_LO_BITS 32
`define BLINK_CLOCK_DIV 26

// Management link and UART1
`define PIN_JTAG 0
`define PIN_SDO 1
`define PIN_SDI 2
`define PIN_CSB 3
`define PIN_SCK 4
`define PIN_UART1_RX 5
`define PIN_UART1_TX 6

// IRQ and flash
`define PIN_IRQ 7
`define PIN_FLASH_CSB 8
`define PIN_FLASH_SCK 9
`define PIN_FLASH_IO0 10
`define PIN_FLASH_IO1 11

// Shared peripheral pads
`define PIN_PWM0 12
`define PIN_PWM6 18
`define PIN_UART2_RX 19
`define PIN_UART2_TX 20
`define PIN_PWM7 21
`define PIN_SPI0_CLK 22
`define PIN_SPI0_MOSI 23
`define PIN_SPI0_MISO 24
`define PIN_SPI0_CS 25
`define PIN_UART3_RX 26
`define PIN_UART3_TX 27
`define PIN_BLINK0 28
`define PIN_BLINK1 29

// VGA block with R0 lowest and HSYNC highest
`define PIN_VGA_R0 30
`define PIN_VGA_HSYNC 37

`endif
